/* Bender.yml */
package:
  name: bp_predictor

sources:
  - hdl/bp_pkg.sv
  - hdl/bp_predecode.sv
  - hdl/bp_direction.sv
  - hdl/bp_btb.sv
  - hdl/bp_ras.sv
  - hdl/bp_select.sv
  - hdl/bp_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/bp_tb.sv

/* hdl/bp_btb.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_btb (
    input  wire                  clk,
    input  wire                  rst,
    input  wire bp_pkg::addr_t   pc_i,
    input  wire                  upd_valid_i,
    input  wire bp_pkg::update_t upd_i,
    output logic                 hit_o,
    output bp_pkg::addr_t        target_o
);
    import bp_pkg::*;

    logic     vld     [btb_entries];
    btb_tag_t tag_mem [btb_entries];
    addr_t    tgt_mem [btb_entries];

    btb_idx_t lk_idx;
    btb_idx_t up_idx;
    logic     fill;

    assign lk_idx = pc_i[5:2];
    assign up_idx = upd_i.pc[5:2];
    assign fill   = upd_valid_i && upd_i.taken;  // only taken transfers get an entry

    assign hit_o    = vld[lk_idx] && (tag_mem[lk_idx] == pc_i[31:32-btb_tag_w]);
    assign target_o = tgt_mem[lk_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                vld[i] <= 1'b0;
            end
        end else if (fill) begin
            vld[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[up_idx] <= upd_i.pc[31:32-btb_tag_w];
            tgt_mem[up_idx] <= upd_i.target;
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_direction.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_direction (
    input  wire                  clk,
    input  wire                  rst,
    input  wire bp_pkg::addr_t   pc_i,
    input  wire                  upd_valid_i,
    input  wire bp_pkg::update_t upd_i,
    output logic                 taken_o,
    output bp_pkg::provider_t    provider_o,
    output bp_pkg::hist_t        history_o
);
    import bp_pkg::*;

    ctr_t     bim_ctr  [bim_entries];
    logic     tg_valid [2][tag_entries];  // [0] short table, [1] long table
    tag_t     tg_tag   [2][tag_entries];
    ctr_t     tg_ctr   [2][tag_entries];
    hist_t    ghist;

    bim_idx_t bim_idx;
    bim_idx_t bim_uidx;
    tag_idx_t tg_idx  [2];
    tag_idx_t tg_uidx [2];
    tag_t     tg_utag [2];
    logic     tg_hit  [2];
    logic     upd_br;
    logic     prov_tbl;   // tagged table that provided the updated prediction
    logic     alloc_tbl;  // table that receives a new entry

    function automatic tag_idx_t tbl_index(input addr_t pc, input hist_t h, input logic lng);
        return pc[6:2] ^ (lng ? h[15:11] : h[4:0]);
    endfunction

    // long table folds all 16 history bits into the tag
    function automatic tag_t tbl_tag(input addr_t pc, input hist_t h, input logic lng);
        tag_t fold;
        fold = lng ? (h[5:0] ^ h[11:6] ^ {2'b00, h[15:12]}) : {1'b0, h[4:0]};
        return pc[12:7] ^ fold;
    endfunction

    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // lookup
    always_comb begin
        bim_idx = pc_i[7:2];
        for (int t = 0; t < 2; t++) begin
            tg_idx[t] = tbl_index(pc_i, ghist, t[0]);
            tg_hit[t] = tg_valid[t][tg_idx[t]] &&
                        (tg_tag[t][tg_idx[t]] == tbl_tag(pc_i, ghist, t[0]));
        end
    end

    always_comb begin
        if (tg_hit[1]) begin
            provider_o = prov_long;
            taken_o    = tg_ctr[1][tg_idx[1]][1];
        end else if (tg_hit[0]) begin
            provider_o = prov_short;
            taken_o    = tg_ctr[0][tg_idx[0]][1];
        end else begin
            provider_o = prov_bim;
            taken_o    = bim_ctr[bim_idx][1];
        end
    end

    assign history_o = ghist;

    // update side, indexed with the history seen at lookup
    assign upd_br = upd_valid_i && (upd_i.kind == kind_branch);

    always_comb begin
        bim_uidx = upd_i.pc[7:2];
        for (int t = 0; t < 2; t++) begin
            tg_uidx[t] = tbl_index(upd_i.pc, upd_i.meta.history, t[0]);
            tg_utag[t] = tbl_tag(upd_i.pc, upd_i.meta.history, t[0]);
        end
    end

    assign prov_tbl  = (upd_i.meta.provider == prov_long);
    // long table unless it already holds this branch
    assign alloc_tbl = !(tg_valid[1][tg_uidx[1]] && (tg_tag[1][tg_uidx[1]] == tg_utag[1]));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < bim_entries; i++) begin
                bim_ctr[i] <= ctr_init;
            end
            for (int t = 0; t < 2; t++) begin
                for (int i = 0; i < tag_entries; i++) begin
                    tg_valid[t][i] <= 1'b0;
                end
            end
        end else if (upd_br) begin
            ghist <= {ghist[$bits(hist_t)-2:0], upd_i.taken};
            bim_ctr[bim_uidx] <= ctr_step(bim_ctr[bim_uidx], upd_i.taken);
            if (upd_i.meta.provider == prov_bim && upd_i.mispredict) begin
                tg_valid[alloc_tbl][tg_uidx[alloc_tbl]] <= 1'b1;
            end
        end
    end

    // tags and counters only matter behind a valid bit
    always_ff @(posedge clk) begin
        if (upd_br) begin
            if (upd_i.meta.provider == prov_bim) begin
                if (upd_i.mispredict) begin
                    tg_tag[alloc_tbl][tg_uidx[alloc_tbl]] <= tg_utag[alloc_tbl];
                    tg_ctr[alloc_tbl][tg_uidx[alloc_tbl]] <= upd_i.taken ? 2'd2 : 2'd1;
                end
            end else if (upd_i.mispredict) begin
                tg_ctr[prov_tbl][tg_uidx[prov_tbl]] <= upd_i.taken ? 2'd3 : 2'd0;
            end else begin
                tg_ctr[prov_tbl][tg_uidx[prov_tbl]] <=
                    ctr_step(tg_ctr[prov_tbl][tg_uidx[prov_tbl]], upd_i.taken);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // table sizes
    localparam int bim_entries = 64;
    localparam int tag_entries = 32;
    localparam int btb_entries = 16;
    localparam int ras_depth   = 8;

    localparam int btb_tag_w = 32 - 2 - $clog2(btb_entries);  // pc bits above the index

    // rv32 opcodes of control transfers
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [15:0] hist_t;
    typedef logic [1:0]  ctr_t;       // 2 and 3 predict taken
    typedef logic [5:0]  tag_t;
    typedef logic [1:0]  provider_t;
    typedef logic [3:0]  ras_ptr_t;   // 0 .. ras_depth

    typedef logic [$clog2(bim_entries)-1:0] bim_idx_t;
    typedef logic [$clog2(tag_entries)-1:0] tag_idx_t;
    typedef logic [$clog2(btb_entries)-1:0] btb_idx_t;
    typedef logic [$clog2(ras_depth)-1:0]   ras_idx_t;
    typedef logic [btb_tag_w-1:0]           btb_tag_t;

    localparam ctr_t ctr_init = 2'd1;  // weakly not taken

    localparam provider_t prov_bim   = 2'd0;
    localparam provider_t prov_short = 2'd1;
    localparam provider_t prov_long  = 2'd2;

    typedef enum logic [2:0] {
        kind_other,
        kind_branch,
        kind_jal,
        kind_jalr,
        kind_ret
    } bp_kind_e;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        addr_t    pc;
        bp_kind_e kind;
        addr_t    static_target;  // pc + branch or jal offset
    } pre_t;

    // lookup state carried to execute and echoed back on update
    typedef struct packed {
        hist_t     history;
        provider_t provider;
        ras_ptr_t  ras_sp;
        logic      used_ras;
    } meta_t;

    typedef struct packed {
        addr_t pc;
        logic  is_cti;
        logic  taken;
        addr_t next_pc;
        meta_t meta;
    } pred_t;

    typedef struct packed {
        addr_t    pc;
        bp_kind_e kind;
        logic     taken;
        logic     mispredict;
        addr_t    target;
        meta_t    meta;
    } update_t;

endpackage

`default_nettype wire

/* hdl/bp_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_predecode (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 stall_i,
    input  wire                 fetch_valid_i,
    input  wire bp_pkg::fetch_t fetch_i,
    output logic                s1_valid_o,
    output bp_pkg::pre_t        s1_o
);
    import bp_pkg::*;

    inst_t    inst;
    logic     is_ret;
    bp_kind_e kind;
    addr_t    b_off;
    addr_t    j_off;
    pre_t     pre_d;

    assign inst = fetch_i.inst;

    // jalr x0, 0(x1)
    assign is_ret = (inst[11:7] == 5'd0) && (inst[19:15] == 5'd1) && (inst[31:20] == 12'd0);

    always_comb begin
        case (inst[6:0])
            op_branch: kind = kind_branch;
            op_jal:    kind = kind_jal;
            op_jalr:   kind = is_ret ? kind_ret : kind_jalr;
            default:   kind = kind_other;
        endcase
    end

    assign b_off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign j_off = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pre_d.pc            = fetch_i.pc;
    assign pre_d.kind          = kind;
    assign pre_d.static_target = fetch_i.pc + ((kind == kind_jal) ? j_off : b_off);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else if (!stall_i) begin
            s1_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            s1_o <= pre_d;  // payload qualified by s1_valid_o
        end
    end

    a_kind_known: assert property (@(posedge clk) disable iff (rst)
        s1_valid_o |-> !$isunknown(s1_o.kind));

endmodule

`default_nettype wire

/* hdl/bp_ras.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_ras (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  stall_i,
    input  wire                  push_valid_i,
    input  wire bp_pkg::addr_t   push_addr_i,
    input  wire                  upd_valid_i,
    input  wire bp_pkg::update_t upd_i,
    output bp_pkg::addr_t        top_o,
    output logic                 nonempty_o,
    output bp_pkg::ras_ptr_t     sp_o
);
    import bp_pkg::*;

    addr_t    stack [ras_depth];
    ras_ptr_t sp;      // next free slot
    ras_ptr_t sp_dec;
    ras_idx_t wr_idx;
    logic     push_ok;
    logic     pop;
    logic     restore;

    assign sp_dec  = sp - ras_ptr_t'(1);
    assign push_ok = push_valid_i && !stall_i && (sp < ras_ptr_t'(ras_depth));
    assign pop     = upd_valid_i && upd_i.taken && (upd_i.kind == kind_ret) && (sp != '0);
    assign restore = upd_valid_i && upd_i.mispredict && upd_i.meta.used_ras;

    // a push in the same cycle as a pop reuses the popped slot
    assign wr_idx = pop ? ras_idx_t'(sp_dec) : ras_idx_t'(sp);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else if (restore) begin
            sp <= upd_i.meta.ras_sp;  // back to sp seen at lookup
        end else if (push_ok && !pop) begin
            sp <= sp + ras_ptr_t'(1);
        end else if (pop && !push_ok) begin
            sp <= sp_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok && !restore) begin
            stack[wr_idx] <= push_addr_i;
        end
    end

    assign top_o      = stack[ras_idx_t'(sp_dec)];  // don't care while empty
    assign nonempty_o = (sp != '0);
    assign sp_o       = sp;

    a_sp_range: assert property (@(posedge clk) disable iff (rst)
        sp <= ras_ptr_t'(ras_depth));

endmodule

`default_nettype wire

/* hdl/bp_select.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_select (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    stall_i,
    input  wire                    s1_valid_i,
    input  wire bp_pkg::pre_t      s1_i,
    input  wire                    dir_taken_i,
    input  wire bp_pkg::provider_t provider_i,
    input  wire bp_pkg::hist_t     history_i,
    input  wire                    btb_hit_i,
    input  wire bp_pkg::addr_t     btb_target_i,
    input  wire bp_pkg::addr_t     ras_top_i,
    input  wire                    ras_nonempty_i,
    input  wire bp_pkg::ras_ptr_t  ras_sp_i,
    output logic                   pred_valid_o,
    output bp_pkg::pred_t          pred_o
);
    import bp_pkg::*;

    pred_t pred_d;
    addr_t seq_pc;

    assign seq_pc = s1_i.pc + 32'd4;

    always_comb begin
        pred_d.pc            = s1_i.pc;
        pred_d.is_cti        = (s1_i.kind != kind_other);
        pred_d.taken         = 1'b0;
        pred_d.next_pc       = seq_pc;
        pred_d.meta.history  = history_i;
        pred_d.meta.provider = provider_i;
        pred_d.meta.ras_sp   = ras_sp_i;
        pred_d.meta.used_ras = 1'b0;

        case (s1_i.kind)
            kind_ret: begin
                if (ras_nonempty_i) begin
                    pred_d.taken         = 1'b1;
                    pred_d.next_pc       = ras_top_i;
                    pred_d.meta.used_ras = 1'b1;
                end else if (btb_hit_i) begin  // empty stack falls back to the btb
                    pred_d.taken   = 1'b1;
                    pred_d.next_pc = btb_target_i;
                end
            end
            kind_jal: begin
                pred_d.taken   = 1'b1;
                pred_d.next_pc = btb_hit_i ? btb_target_i : s1_i.static_target;
            end
            kind_jalr: begin
                // no static target for an indirect jump
                if (btb_hit_i) begin
                    pred_d.taken   = 1'b1;
                    pred_d.next_pc = btb_target_i;
                end
            end
            kind_branch: begin
                if (dir_taken_i) begin
                    pred_d.taken   = 1'b1;
                    pred_d.next_pc = btb_hit_i ? btb_target_i : s1_i.static_target;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pred_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pred_o <= pred_d;
        end
    end

endmodule

`default_nettype wire

/* hdl/bp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  fetch_valid_i,
    input  wire bp_pkg::fetch_t  fetch_i,
    input  wire                  stall_i,
    input  wire                  push_valid_i,
    input  wire bp_pkg::addr_t   push_addr_i,
    input  wire                  upd_valid_i,
    input  wire bp_pkg::update_t upd_i,
    output logic                 pred_valid_o,
    output bp_pkg::pred_t        pred_o,
    output bp_pkg::hist_t        history_o
);
    import bp_pkg::*;

    logic      s1_valid;
    pre_t      s1;
    logic      dir_taken;
    provider_t provider;
    logic      btb_hit;
    addr_t     btb_target;
    addr_t     ras_top;
    logic      ras_nonempty;
    ras_ptr_t  ras_sp;

    bp_predecode bp_predecode_i (
        .clk(clk), .rst(rst), .stall_i(stall_i),
        .fetch_valid_i(fetch_valid_i), .fetch_i(fetch_i),
        .s1_valid_o(s1_valid), .s1_o(s1)
    );

    // predictors look up the stage-1 pc
    bp_direction bp_direction_i (
        .clk(clk), .rst(rst), .pc_i(s1.pc),
        .upd_valid_i(upd_valid_i), .upd_i(upd_i),
        .taken_o(dir_taken), .provider_o(provider), .history_o(history_o)
    );

    bp_btb bp_btb_i (
        .clk(clk), .rst(rst), .pc_i(s1.pc),
        .upd_valid_i(upd_valid_i), .upd_i(upd_i),
        .hit_o(btb_hit), .target_o(btb_target)
    );

    bp_ras bp_ras_i (
        .clk(clk), .rst(rst), .stall_i(stall_i),
        .push_valid_i(push_valid_i), .push_addr_i(push_addr_i),
        .upd_valid_i(upd_valid_i), .upd_i(upd_i),
        .top_o(ras_top), .nonempty_o(ras_nonempty), .sp_o(ras_sp)
    );

    bp_select bp_select_i (
        .clk(clk), .rst(rst), .stall_i(stall_i),
        .s1_valid_i(s1_valid), .s1_i(s1),
        .dir_taken_i(dir_taken), .provider_i(provider), .history_i(history_o),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .ras_top_i(ras_top), .ras_nonempty_i(ras_nonempty), .ras_sp_i(ras_sp),
        .pred_valid_o(pred_valid_o), .pred_o(pred_o)
    );

endmodule

`default_nettype wire

/* test/bp_tb_vectors.svh */
`ifndef BP_TB_VECTORS_SVH
`define BP_TB_VECTORS_SVH

typedef enum logic [2:0] {
    do_fetch,
    do_push,
    do_push_stalled,
    do_update,
    do_hist,
    do_stall_hold,
    do_burst
} step_op_e;

typedef struct packed {
    step_op_e op;
    addr_t    pc;
    inst_t    inst;
    addr_t    addr;   // push address
    update_t  upd;
    pred_t    exp;    // expected prediction
    hist_t    hist;   // expected history_o
} step_t;

localparam inst_t inst_beq = 32'h0000_0863;  // beq x0, x0, +16
localparam inst_t inst_jal = 32'h1000_00ef;  // jal x1, +256
localparam inst_t inst_ret = 32'h0000_8067;  // jalr x0, 0(x1)
localparam inst_t inst_nop = 32'h0000_0013;

step_t steps [$];

function automatic step_t fetch_step(input step_op_e op, input addr_t pc, input inst_t inst,
                                     input logic cti, input logic tk, input addr_t nxt,
                                     input hist_t h, input provider_t pv, input ras_ptr_t sp,
                                     input logic ras);
    step_t s;
    s = '0;
    s.op = op;
    s.pc = pc;
    s.inst = inst;
    s.exp = '{pc, cti, tk, nxt, '{h, pv, sp, ras}};
    return s;
endfunction

// resolved outcome, meta as echoed from its prediction
function automatic step_t update_step(input addr_t pc, input bp_kind_e kind, input logic tk,
                                      input logic mis, input addr_t tgt, input hist_t h,
                                      input provider_t pv, input ras_ptr_t sp, input logic ras);
    step_t s;
    s = '0;
    s.op = do_update;
    s.upd = '{pc, kind, tk, mis, tgt, '{h, pv, sp, ras}};
    return s;
endfunction

function automatic step_t push_step(input step_op_e op, input addr_t addr);
    step_t s;
    s = '0;
    s.op = op;
    s.addr = addr;
    return s;
endfunction

function automatic step_t hist_step(input hist_t h);
    step_t s;
    s = '0;
    s.op = do_hist;
    s.hist = h;
    return s;
endfunction

// fetch columns: op, pc, inst, is_cti, taken, next_pc, history, provider, ras_sp, used_ras
// update columns: pc, kind, taken, mispredict, target, history, provider, ras_sp, used_ras
task automatic load_steps();
    // cold tables
    steps.push_back(fetch_step(do_fetch, 'h100, inst_beq, 1, 0, 'h104, 'h0, 0, 0, 0));
    steps.push_back(fetch_step(do_fetch, 'h200, inst_jal, 1, 1, 'h300, 'h0, 0, 0, 0));
    steps.push_back(fetch_step(do_fetch, 'h204, inst_nop, 0, 0, 'h208, 'h0, 0, 0, 0));
    // bimodal 1 -> 3, btb filled with a target off the static one
    steps.push_back(update_step('h100, kind_branch, 1, 0, 'h140, 'h0, 0, 0, 0));
    steps.push_back(update_step('h100, kind_branch, 1, 0, 'h140, 'h1, 0, 0, 0));
    steps.push_back(hist_step('h3));
    steps.push_back(fetch_step(do_fetch, 'h100, inst_beq, 1, 1, 'h140, 'h3, 0, 0, 0));
    // bimodal miss allocates long entry 17, tag 1, counter 2
    steps.push_back(update_step('h344, kind_branch, 1, 1, 'h354, 'h7, 0, 0, 0));
    steps.push_back(hist_step('h7));
    steps.push_back(fetch_step(do_fetch, 'h344, inst_beq, 1, 1, 'h354, 'h7, 2, 0, 0));
    // return stack
    steps.push_back(push_step(do_push, 'h1000));
    steps.push_back(push_step(do_push, 'h2000));
    steps.push_back(fetch_step(do_fetch, 'h400, inst_ret, 1, 1, 'h2000, 'h7, 0, 2, 1));
    steps.push_back(update_step('h400, kind_ret, 1, 0, 'h2000, 'h7, 0, 2, 1));
    steps.push_back(fetch_step(do_fetch, 'h500, inst_ret, 1, 1, 'h1000, 'h7, 0, 1, 1));
    steps.push_back(update_step('h500, kind_ret, 1, 1, 'h3000, 'h7, 0, 1, 1));  // restore, no pop
    steps.push_back(fetch_step(do_fetch, 'h600, inst_ret, 1, 1, 'h1000, 'h7, 0, 1, 1));
    steps.push_back(update_step('h600, kind_ret, 1, 0, 'h1000, 'h7, 0, 1, 1));  // now empty
    // empty stack falls back to the btb
    steps.push_back(fetch_step(do_fetch, 'h704, inst_ret, 1, 0, 'h708, 'h7, 0, 0, 0));
    steps.push_back(update_step('h704, kind_ret, 1, 1, 'h5000, 'h7, 0, 0, 0));
    steps.push_back(fetch_step(do_fetch, 'h704, inst_ret, 1, 1, 'h5000, 'h7, 0, 0, 0));
    steps.push_back(push_step(do_push_stalled, 'h6000));
    steps.push_back(fetch_step(do_fetch, 'h704, inst_ret, 1, 1, 'h5000, 'h7, 0, 0, 0));
    // pipelining and back-pressure
    steps.push_back(fetch_step(do_burst, 'h800, inst_nop, 0, 0, 'h804, 'h7, 0, 0, 0));
    steps.push_back(fetch_step(do_stall_hold, 'h900, inst_nop, 0, 0, 'h904, 'h7, 0, 0, 0));
    steps.push_back(hist_step('h7));
endtask

`endif

/* test/bp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_tb;
    import bp_pkg::*;

    logic    clk = 1'b0;
    logic    rst;
    logic    fetch_valid;
    fetch_t  fetch;
    logic    stall;
    logic    push_valid;
    addr_t   push_addr;
    logic    upd_valid;
    update_t upd;
    logic    pred_valid;
    pred_t   pred;
    hist_t   history;

    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    int      cycle_limit = 1000;  // replaced once the table is loaded
    integer  seed = 84185;

    `include "bp_tb_vectors.svh"

    bp_top bp_top_i (
        .clk(clk), .rst(rst),
        .fetch_valid_i(fetch_valid), .fetch_i(fetch), .stall_i(stall),
        .push_valid_i(push_valid), .push_addr_i(push_addr),
        .upd_valid_i(upd_valid), .upd_i(upd),
        .pred_valid_o(pred_valid), .pred_o(pred), .history_o(history)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pred(input pred_t got, input pred_t exp);
        compare_field("pred_o.pc", got.pc, exp.pc);
        compare_field("pred_o.is_cti", 32'(got.is_cti), 32'(exp.is_cti));
        compare_field("pred_o.taken", 32'(got.taken), 32'(exp.taken));
        compare_field("pred_o.next_pc", got.next_pc, exp.next_pc);
        compare_field("pred_o.meta.history", 32'(got.meta.history), 32'(exp.meta.history));
        compare_field("pred_o.meta.provider", 32'(got.meta.provider), 32'(exp.meta.provider));
        compare_field("pred_o.meta.ras_sp", 32'(got.meta.ras_sp), 32'(exp.meta.ras_sp));
        compare_field("pred_o.meta.used_ras", 32'(got.meta.used_ras), 32'(exp.meta.used_ras));
    endtask

    task automatic check_hist(input hist_t got, input hist_t exp);
        compare_field("history_o", 32'(got), 32'(exp));
    endtask

    // max_wait 0 means it must be valid now
    task automatic collect_pred(input pred_t exp, input int max_wait);
        int n;
        n = 0;
        while (!pred_valid && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (pred_valid) begin
            check_pred(pred, exp);
        end else begin
            errors++;
            $display("no prediction for pc %h arrived within %0d cycles", exp.pc, max_wait);
        end
    endtask

    task automatic issue_fetch(input addr_t pc, input inst_t inst);
        fetch_valid = 1'b1;
        fetch.pc    = pc;
        fetch.inst  = inst;
        @(negedge clk);
    endtask

    task automatic run_step(input step_t s);
        pred_t next_exp;
        int    hold;
        hold = 1 + ($unsigned($random(seed)) % 4);
        case (s.op)
            do_fetch: begin
                issue_fetch(s.pc, s.inst);
                fetch_valid = 1'b0;
                compare_field("pred_valid_o", 32'(pred_valid), 32'd0);  // still in stage 1
                @(negedge clk);
                collect_pred(s.exp, 10);
            end
            do_burst: begin
                // second fetch is the same kind one word later
                next_exp         = s.exp;
                next_exp.pc      = s.pc + 32'd4;
                next_exp.next_pc = s.exp.next_pc + 32'd4;
                issue_fetch(s.pc, s.inst);
                issue_fetch(s.pc + 32'd4, s.inst);
                fetch_valid = 1'b0;
                collect_pred(s.exp, 0);
                @(negedge clk);
                collect_pred(next_exp, 0);
            end
            do_stall_hold: begin
                issue_fetch(s.pc, s.inst);
                fetch_valid = 1'b0;
                stall = 1'b1;  // item parked in stage 1
                repeat (hold) @(negedge clk);
                stall = 1'b0;
                @(negedge clk);
                collect_pred(s.exp, 10);
                stall = 1'b1;
                repeat (hold) begin
                    @(negedge clk);
                    collect_pred(s.exp, 0);  // held output
                end
                stall = 1'b0;
            end
            do_push, do_push_stalled: begin
                push_valid = 1'b1;
                push_addr  = s.addr;
                stall      = (s.op == do_push_stalled);
                @(negedge clk);
                push_valid = 1'b0;
                stall      = 1'b0;
            end
            do_update: begin
                upd_valid = 1'b1;
                upd       = s.upd;
                @(negedge clk);
                upd_valid = 1'b0;
            end
            do_hist: begin
                check_hist(history, s.hist);
            end
            default: begin
                errors++;
                $display("unknown step in the vector table");
            end
        endcase
    endtask

    initial begin
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        stall       = 1'b0;
        push_valid  = 1'b0;
        push_addr   = '0;
        upd_valid   = 1'b0;
        upd         = '0;
        load_steps();
        cycle_limit = 4 * steps.size() + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        repeat (2) @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+test
hdl/bp_pkg.sv
hdl/bp_predecode.sv
hdl/bp_direction.sv
hdl/bp_btb.sv
hdl/bp_ras.sv
hdl/bp_select.sv
hdl/bp_top.sv
test/bp_tb.sv
